// ==== dv/tb_clk_gen.sv ====
// Testbench clock and reset source
// Reset is held low for ResetCycles rising edges and released on a falling edge
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real         PeriodNs    = 4.0,
  parameter int unsigned ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_n_o
);
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== dv/tb_dma_desc_top.sv ====
// Testbench of the descriptor DMA: builds descriptors in the memory model, runs
// them through the register port and compares the whole memory with a model copy
`timescale 1ns/1ps

module tb_dma_desc_top;
  localparam int unsigned QueueDepth   = 4;
  localparam int unsigned PendingDepth = 2;
  localparam int unsigned MemWords     = 1024;
  localparam int unsigned NumDesc      = 16;  // Descriptors over all tests
  localparam int unsigned MaxLen       = 8;
  localparam int unsigned CycleLimit   = 40 * NumDesc * (4 + MaxLen) + 2000;
  localparam logic [31:0] Seed         = 32'h3f1f_6cfb;

  logic        clk;
  logic        rst_n;
  logic        reg_valid;
  logic        reg_we;
  logic [31:0] reg_addr;
  logic [31:0] reg_wdata;
  logic        reg_rvalid;
  logic [31:0] reg_rdata;
  logic        irq;
  logic        stall;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_gnt;
  logic        mem_rvalid;
  logic [31:0] mem_rdata;

  logic [31:0] model_mem [MemWords];
  int unsigned desc_len [NumDesc];
  logic [31:0] rand_state;
  logic [31:0] done_total;
  int unsigned error_cnt;
  int unsigned test_errs;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned cycle_cnt;

  tb_clk_gen #(.PeriodNs(4.0), .ResetCycles(2)) i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  tb_mem_model #(.Words(MemWords), .Seed(Seed)) i_mem (
    .clk_i(clk), .rst_n_i(rst_n), .stall_i(stall),
    .req_i(mem_req), .we_i(mem_we), .addr_i(mem_addr), .wdata_i(mem_wdata),
    .gnt_o(mem_gnt), .rvalid_o(mem_rvalid), .rdata_o(mem_rdata)
  );

  dma_desc_top #(.QueueDepth(QueueDepth), .PendingDepth(PendingDepth)) dut (
    .clk_i(clk), .rst_n_i(rst_n),
    .reg_valid_i(reg_valid), .reg_write_i(reg_we), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_rvalid_o(reg_rvalid), .reg_rdata_o(reg_rdata),
    .irq_o(irq),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_gnt_i(mem_gnt), .mem_rvalid_i(mem_rvalid),
    .mem_rdata_i(mem_rdata)
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic int unsigned rand_len();
    return ((next_rand() >> 16) % MaxLen) + 1;
  endfunction

  // Slot k: descriptor at word 4k, source at word 256+8k, destination at 512+8k
  function automatic int unsigned desc_word(input int unsigned slot);
    return slot * 4;
  endfunction

  function automatic int unsigned src_word(input int unsigned slot);
    return 256 + slot * 8;
  endfunction

  function automatic int unsigned dst_word(input int unsigned slot);
    return 512 + slot * 8;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      error_cnt++;
    end
  endtask

  task automatic write_word(input int unsigned idx, input logic [31:0] data);
    i_mem.mem_q[idx] = data;
    model_mem[idx]   = data;
  endtask

  task automatic init_memory();
    int unsigned i;
    for (i = 0; i < MemWords; i++) write_word(i, 32'h6b00_0000 ^ (i * 32'h0001_0003));
  endtask

  task automatic build_desc(input int unsigned slot, input int unsigned len, input bit irq_en);
    int unsigned i;
    int unsigned base;
    base = desc_word(slot);
    desc_len[slot] = len;
    for (i = 0; i < len; i++) write_word(src_word(slot) + i, next_rand());
    write_word(base + int'(dma_xfer_pkg::DESC_SRC), src_word(slot) * 4);
    write_word(base + int'(dma_xfer_pkg::DESC_DST), dst_word(slot) * 4);
    write_word(base + int'(dma_xfer_pkg::DESC_CTRL), {irq_en, 15'b0, 16'(len)});
    write_word(base + int'(dma_xfer_pkg::DESC_STATUS), 32'h0);
  endtask

  // Expected effect of one completed descriptor on the model memory
  task automatic apply_model(input int unsigned slot);
    int unsigned i;
    for (i = 0; i < desc_len[slot]; i++) begin
      model_mem[dst_word(slot) + i] = model_mem[src_word(slot) + i];
    end
    model_mem[desc_word(slot) + int'(dma_xfer_pkg::DESC_STATUS)] =
      (desc_len[slot] == 0) ? dma_xfer_pkg::DESC_REJECTED : dma_xfer_pkg::DESC_DONE;
  endtask

  // Register tasks start and end on a falling edge
  task automatic write_reg(input dma_cfg_pkg::reg_addr_e addr, input logic [31:0] data);
    reg_valid = 1'b1;
    reg_we    = 1'b1;
    reg_addr  = 32'(addr);
    reg_wdata = data;
    @(negedge clk);
    reg_valid = 1'b0;
    reg_we    = 1'b0;
  endtask

  task automatic read_reg(input dma_cfg_pkg::reg_addr_e addr, output logic [31:0] data);
    reg_valid = 1'b1;
    reg_we    = 1'b0;
    reg_addr  = 32'(addr);
    @(negedge clk);
    reg_valid = 1'b0;
    check_value("reg_rvalid_o", {31'b0, reg_rvalid}, 32'h1);
    data = reg_rdata;
  endtask

  task automatic queue_desc(input int unsigned slot);
    write_reg(dma_cfg_pkg::REG_QUEUE, desc_word(slot) * 4);
  endtask

  task automatic queue_when_room(input int unsigned slot);
    logic [31:0] v;
    read_reg(dma_cfg_pkg::REG_STATUS, v);
    while (v[dma_cfg_pkg::StatFull]) read_reg(dma_cfg_pkg::REG_STATUS, v);
    queue_desc(slot);
  endtask

  task automatic wait_done(input logic [31:0] target);
    logic [31:0] v;
    read_reg(dma_cfg_pkg::REG_DONE_COUNT, v);
    while (v < target) read_reg(dma_cfg_pkg::REG_DONE_COUNT, v);
    check_value("DONE_COUNT", v, target);
  endtask

  task automatic compare_memory();
    int unsigned i;
    for (i = 0; i < MemWords; i++) begin
      check_value($sformatf("mem[0x%03h]", i * 4), i_mem.mem_q[i], model_mem[i]);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_cnt != test_errs) begin
      tests_failed++;
      $display("Test %0d %s: %0d check(s) failed", tests_run, name, error_cnt - test_errs);
    end else begin
      $display("Test %0d %s: ok", tests_run, name);
    end
    test_errs = error_cnt;
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CycleLimit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the DMA did not finish within %0d cycles", CycleLimit);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic [31:0] v;
    int unsigned k;
    reg_valid    = 1'b0;
    reg_we       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    stall        = 1'b0;
    rand_state   = Seed;
    done_total   = '0;
    error_cnt    = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    init_memory();
    wait (rst_n === 1'b1);
    @(negedge clk);

    check_value("irq_o", {31'b0, irq}, 32'h0);
    read_reg(dma_cfg_pkg::REG_STATUS, v);
    check_value("STATUS", v, 32'h0);
    read_reg(dma_cfg_pkg::REG_DONE_COUNT, v);
    check_value("DONE_COUNT", v, 32'h0);
    finish_test("reset values");

    build_desc(0, rand_len(), 1'b0);
    apply_model(0);
    queue_desc(0);
    done_total++;
    wait_done(done_total);
    read_reg(dma_cfg_pkg::REG_STATUS, v);
    check_value("STATUS", v, 32'h0);  // Busy back to 0
    compare_memory();
    finish_test("single copy");

    for (k = 1; k <= 6; k++) begin
      build_desc(k, rand_len(), 1'b0);
      apply_model(k);
    end
    for (k = 1; k <= 6; k++) queue_when_room(k);
    done_total += 6;
    wait_done(done_total);
    read_reg(dma_cfg_pkg::REG_STATUS, v);
    check_value("STATUS", v, 32'h0);
    compare_memory();
    finish_test("back-to-back chain");

    build_desc(7, 0, 1'b0);
    apply_model(7);
    queue_desc(7);
    done_total++;
    wait_done(done_total);
    compare_memory();
    finish_test("zero length");

    build_desc(8, rand_len(), 1'b1);
    build_desc(9, rand_len(), 1'b0);
    apply_model(8);
    apply_model(9);
    queue_desc(8);
    done_total++;
    wait_done(done_total);
    check_value("irq_o", {31'b0, irq}, 32'h1);
    read_reg(dma_cfg_pkg::REG_STATUS, v);
    check_value("STATUS", v, 32'h1 << dma_cfg_pkg::StatIrq);
    write_reg(dma_cfg_pkg::REG_IRQ_CLEAR, 32'h1);
    check_value("irq_o", {31'b0, irq}, 32'h0);
    read_reg(dma_cfg_pkg::REG_STATUS, v);
    check_value("STATUS", v, 32'h0);
    queue_desc(9);
    done_total++;
    wait_done(done_total);
    check_value("irq_o", {31'b0, irq}, 32'h0);
    compare_memory();
    finish_test("interrupt");

    // First address is popped at once, the next QueueDepth fill the queue
    for (k = 10; k < 10 + QueueDepth + 2; k++) build_desc(k, rand_len(), 1'b0);
    for (k = 10; k < 10 + QueueDepth + 1; k++) apply_model(k);
    stall = 1'b1;
    for (k = 10; k < 10 + QueueDepth + 2; k++) queue_desc(k);
    read_reg(dma_cfg_pkg::REG_STATUS, v);
    check_value("STATUS", v, (32'h1 << dma_cfg_pkg::StatBusy) |
                             (32'h1 << dma_cfg_pkg::StatFull) |
                             (32'h1 << dma_cfg_pkg::StatOverflow));
    stall = 1'b0;
    done_total += QueueDepth + 1;
    wait_done(done_total);
    read_reg(dma_cfg_pkg::REG_STATUS, v);
    check_value("STATUS", v, 32'h1 << dma_cfg_pkg::StatOverflow);
    compare_memory();  // Dropped descriptor keeps status 0
    finish_test("overflow");

    $display("Tests: %0d run, %0d failed, checks failed: %0d",
             tests_run, tests_failed, error_cnt);
    if (error_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/tb_mem_model.sv ====
// Word-addressed memory on the DMA's request/grant/response port
// Grants after a random delay of 0 to 3 cycles, rvalid follows one cycle after
// the grant, and stall_i holds gnt low while it is set
`timescale 1ns/1ps

module tb_mem_model #(
  parameter int unsigned Words = 1024,
  parameter logic [31:0] Seed  = 32'h3f1f_6cfb
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        stall_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);
  localparam int unsigned AddrBits = $clog2(Words);

  logic [31:0]         mem_q [Words];
  logic                acc_q;      // Access granted at the last rising edge
  logic [AddrBits-1:0] acc_idx_q;
  logic                gnt_q;
  logic [1:0]          wait_q;
  logic [31:0]         rand_q;
  logic [31:0]         rand_next;

  function automatic logic [31:0] step_lcg(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  assign rand_next = step_lcg(rand_q);
  assign gnt_o     = gnt_q && !stall_i;

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q     <= 1'b0;
      acc_idx_q <= '0;
    end else begin
      acc_q <= req_i && gnt_o;
      if (req_i && gnt_o) begin
        acc_idx_q <= addr_i[AddrBits+1:2];
        if (we_i) mem_q[addr_i[AddrBits+1:2]] <= wdata_i;
      end
    end
  end

  // Responses and grants change on the falling edge only
  always @(negedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gnt_q    <= 1'b0;
      wait_q   <= 2'd0;
      rand_q   <= Seed;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= acc_q;
      rdata_o  <= mem_q[acc_idx_q];
      if (acc_q) begin
        gnt_q  <= 1'b0;
        rand_q <= rand_next;
        wait_q <= rand_next[17:16];  // Delay for the next access
      end else if (req_i && !gnt_q) begin
        if (wait_q == 2'd0) gnt_q <= 1'b1;
        else wait_q <= wait_q - 2'd1;
      end else if (!req_i) begin
        gnt_q <= 1'b0;
      end
    end
  end

endmodule

// ==== hw/dma_cfg_pkg.sv ====
// Register map and bus widths of the descriptor DMA
// Shared by the register block, the memory port and the top level

package dma_cfg_pkg;

  // Word width of the memory port and of the register bus
  localparam int unsigned DataWidth = 32;

  typedef logic [DataWidth-1:0] word_t;

  // Byte offsets, only the low nibble of the register address is decoded
  localparam int unsigned RegAddrBits = 4;

  typedef enum logic [RegAddrBits-1:0] {
    REG_QUEUE      = 4'h0,  // Write pushes a descriptor address
    REG_STATUS     = 4'h4,
    REG_DONE_COUNT = 4'h8,
    REG_IRQ_CLEAR  = 4'hC   // Bit 0 clears irq and overflow
  } reg_addr_e;

  // Bit positions in REG_STATUS
  localparam int unsigned StatBusy     = 0;
  localparam int unsigned StatFull     = 1;
  localparam int unsigned StatOverflow = 2;
  localparam int unsigned StatIrq      = 3;

endpackage

// ==== hw/dma_copy_engine.sv ====
// Word-granular copy engine that reads each word from the source and then
// writes it to the destination. Zero-length jobs get no memory traffic
`timescale 1ns/1ps

module dma_copy_engine (
  input  logic      clk_i,
  input  logic      rst_n_i,
  dma_xfer_if.back  xfer,
  dma_mem_if.master mem
);
  dma_xfer_pkg::copy_state_e state_q;
  dma_xfer_pkg::len_t        len_q;
  dma_xfer_pkg::len_t        idx_q;
  dma_cfg_pkg::word_t        src_q;
  dma_cfg_pkg::word_t        dst_q;
  dma_cfg_pkg::word_t        data_q;
  dma_cfg_pkg::word_t        offset;
  logic                      rej_q;
  logic                      job_fire;

  assign job_fire = xfer.job_valid && xfer.job_ready;
  assign offset   = dma_cfg_pkg::word_t'({idx_q, 2'b00});

  assign xfer.job_ready    = (state_q == dma_xfer_pkg::COPY_IDLE);
  assign xfer.rsp_valid    = (state_q == dma_xfer_pkg::COPY_RSP);
  assign xfer.rsp_rejected = rej_q;

  assign mem.req   = (state_q == dma_xfer_pkg::COPY_RD) || (state_q == dma_xfer_pkg::COPY_WR);
  assign mem.we    = (state_q == dma_xfer_pkg::COPY_WR);
  assign mem.addr  = mem.we ? dst_q + offset : src_q + offset;
  assign mem.wdata = data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= dma_xfer_pkg::COPY_IDLE;
      idx_q   <= '0;
      rej_q   <= 1'b0;
    end else begin
      unique case (state_q)
        dma_xfer_pkg::COPY_IDLE: begin
          if (job_fire) begin
            idx_q   <= '0;
            rej_q   <= (xfer.job_len == '0);
            state_q <= (xfer.job_len == '0) ? dma_xfer_pkg::COPY_RSP : dma_xfer_pkg::COPY_RD;
          end
        end
        dma_xfer_pkg::COPY_RD: begin
          if (mem.gnt) state_q <= dma_xfer_pkg::COPY_RD_WAIT;
        end
        dma_xfer_pkg::COPY_RD_WAIT: begin
          if (mem.rvalid) state_q <= dma_xfer_pkg::COPY_WR;
        end
        dma_xfer_pkg::COPY_WR: begin
          if (mem.gnt) state_q <= dma_xfer_pkg::COPY_WR_WAIT;
        end
        dma_xfer_pkg::COPY_WR_WAIT: begin
          if (mem.rvalid) begin
            idx_q   <= idx_q + 1'b1;
            state_q <= (idx_q + 1'b1 == len_q) ? dma_xfer_pkg::COPY_RSP : dma_xfer_pkg::COPY_RD;
          end
        end
        dma_xfer_pkg::COPY_RSP: begin
          if (xfer.rsp_ready) state_q <= dma_xfer_pkg::COPY_IDLE;
        end
        default: state_q <= dma_xfer_pkg::COPY_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_fire) begin
      src_q <= xfer.job_src;
      dst_q <= xfer.job_dst;
      len_q <= xfer.job_len;
    end
    if ((state_q == dma_xfer_pkg::COPY_RD_WAIT) && mem.rvalid) data_q <= mem.rdata;
  end

  // Accesses stay inside the job, so a zero-length job never reaches the bus
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem.req |-> idx_q < len_q);

endmodule

// ==== hw/dma_desc_fetch.sv ====
// Descriptor fetcher: reads src, dst and ctrl of a queued descriptor, hands the
// copy job on and later writes the completion code into DESC_STATUS
`timescale 1ns/1ps

module dma_desc_fetch #(
  parameter int unsigned PendingDepth = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               desc_valid_i,
  input  dma_cfg_pkg::word_t desc_addr_i,
  output logic               desc_ready_o,
  output logic               done_o,
  output logic               done_irq_o,
  output logic               busy_o,
  dma_mem_if.master          mem,
  dma_xfer_if.front          xfer
);
  localparam int unsigned PtrW = (PendingDepth > 1) ? $clog2(PendingDepth) : 1;
  localparam int unsigned CntW = $clog2(PendingDepth + 1);

  dma_xfer_pkg::fetch_state_e state_q;
  dma_xfer_pkg::desc_word_e   idx_q;
  dma_cfg_pkg::word_t         cur_addr_q;
  dma_cfg_pkg::word_t         src_q;
  dma_cfg_pkg::word_t         dst_q;
  dma_cfg_pkg::word_t         ctrl_q;
  dma_cfg_pkg::word_t         pend_addr_q [PendingDepth];
  logic                       pend_irq_q [PendingDepth];
  logic [PtrW-1:0]            pend_wr_q;
  logic [PtrW-1:0]            pend_rd_q;
  logic [CntW-1:0]            pend_cnt_q;
  logic                       rsp_hold_q;
  logic                       rsp_rej_q;
  logic                       pop_desc;
  logic                       job_fire;
  logic                       rsp_fire;
  logic                       wb_phase;

  // Pending write-backs go first, new descriptors only while the list has room
  assign desc_ready_o = (state_q == dma_xfer_pkg::FETCH_IDLE) && !rsp_hold_q
                        && (pend_cnt_q != CntW'(PendingDepth));
  assign pop_desc     = desc_valid_i && desc_ready_o;
  assign job_fire     = xfer.job_valid && xfer.job_ready;
  assign rsp_fire     = xfer.rsp_valid && xfer.rsp_ready;

  assign xfer.job_valid = (state_q == dma_xfer_pkg::FETCH_JOB);
  assign xfer.job_src   = src_q;
  assign xfer.job_dst   = dst_q;
  assign xfer.job_len   = ctrl_q[dma_xfer_pkg::LenWidth-1:0];
  assign xfer.rsp_ready = !rsp_hold_q;  // One latched response at a time

  assign wb_phase  = (state_q == dma_xfer_pkg::FETCH_WB);
  assign mem.req   = (state_q == dma_xfer_pkg::FETCH_RD) || wb_phase;
  assign mem.we    = wb_phase;
  assign mem.addr  = wb_phase
                     ? pend_addr_q[pend_rd_q] + {dma_xfer_pkg::DESC_STATUS, 2'b00}
                     : cur_addr_q + {idx_q, 2'b00};
  assign mem.wdata = rsp_rej_q ? dma_xfer_pkg::DESC_REJECTED : dma_xfer_pkg::DESC_DONE;

  assign done_o     = (state_q == dma_xfer_pkg::FETCH_WB_WAIT) && mem.rvalid;
  assign done_irq_o = done_o && pend_irq_q[pend_rd_q];
  assign busy_o     = (state_q != dma_xfer_pkg::FETCH_IDLE) || (pend_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= dma_xfer_pkg::FETCH_IDLE;
      idx_q      <= dma_xfer_pkg::DESC_SRC;
      pend_wr_q  <= '0;
      pend_rd_q  <= '0;
      pend_cnt_q <= '0;
      rsp_hold_q <= 1'b0;
      rsp_rej_q  <= 1'b0;
    end else begin
      if (rsp_fire) begin
        rsp_hold_q <= 1'b1;
        rsp_rej_q  <= xfer.rsp_rejected;
      end
      if (job_fire) begin
        pend_wr_q <= (pend_wr_q == PtrW'(PendingDepth - 1)) ? '0 : pend_wr_q + 1'b1;
      end
      if (done_o) begin
        pend_rd_q  <= (pend_rd_q == PtrW'(PendingDepth - 1)) ? '0 : pend_rd_q + 1'b1;
        rsp_hold_q <= 1'b0;
      end
      pend_cnt_q <= pend_cnt_q + CntW'(job_fire) - CntW'(done_o);

      unique case (state_q)
        dma_xfer_pkg::FETCH_IDLE: begin
          if (rsp_hold_q) begin
            state_q <= dma_xfer_pkg::FETCH_WB;
          end else if (pop_desc) begin
            state_q <= dma_xfer_pkg::FETCH_RD;
            idx_q   <= dma_xfer_pkg::DESC_SRC;
          end
        end
        dma_xfer_pkg::FETCH_RD: begin
          if (mem.gnt) state_q <= dma_xfer_pkg::FETCH_RD_WAIT;
        end
        dma_xfer_pkg::FETCH_RD_WAIT: begin
          if (mem.rvalid) begin
            if (idx_q == dma_xfer_pkg::DESC_CTRL) begin
              state_q <= dma_xfer_pkg::FETCH_JOB;
            end else begin
              idx_q   <= dma_xfer_pkg::desc_word_e'(idx_q + 1'b1);
              state_q <= dma_xfer_pkg::FETCH_RD;
            end
          end
        end
        dma_xfer_pkg::FETCH_JOB: begin
          if (job_fire) state_q <= dma_xfer_pkg::FETCH_IDLE;
        end
        dma_xfer_pkg::FETCH_WB: begin
          if (mem.gnt) state_q <= dma_xfer_pkg::FETCH_WB_WAIT;
        end
        dma_xfer_pkg::FETCH_WB_WAIT: begin
          if (mem.rvalid) state_q <= dma_xfer_pkg::FETCH_IDLE;
        end
        default: state_q <= dma_xfer_pkg::FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_desc) cur_addr_q <= desc_addr_i;
    if ((state_q == dma_xfer_pkg::FETCH_RD_WAIT) && mem.rvalid) begin
      case (idx_q)
        dma_xfer_pkg::DESC_SRC: src_q  <= mem.rdata;
        dma_xfer_pkg::DESC_DST: dst_q  <= mem.rdata;
        default:                ctrl_q <= mem.rdata;
      endcase
    end
    if (job_fire) begin
      pend_addr_q[pend_wr_q] <= cur_addr_q;
      pend_irq_q[pend_wr_q]  <= ctrl_q[dma_xfer_pkg::CtrlIrqBit];
    end
  end

  // The copy engine only answers jobs it was given, so the pop at write-back
  // always finds an entry
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_fire |-> pend_cnt_q != '0);

endmodule

// ==== hw/dma_desc_top.sv ====
// Top level of the descriptor DMA: register slave, fetcher, copy engine and
// memory arbiter, with the shared memory port brought out as plain ports
`timescale 1ns/1ps

module dma_desc_top #(
  parameter int unsigned QueueDepth   = 4,
  parameter int unsigned PendingDepth = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               reg_valid_i,
  input  logic               reg_write_i,
  input  dma_cfg_pkg::word_t reg_addr_i,
  input  dma_cfg_pkg::word_t reg_wdata_i,
  output logic               reg_rvalid_o,
  output dma_cfg_pkg::word_t reg_rdata_o,
  output logic               irq_o,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output dma_cfg_pkg::word_t mem_addr_o,
  output dma_cfg_pkg::word_t mem_wdata_o,
  input  logic               mem_gnt_i,
  input  logic               mem_rvalid_i,
  input  dma_cfg_pkg::word_t mem_rdata_i
);
  logic               desc_valid;
  dma_cfg_pkg::word_t desc_addr;
  logic               desc_ready;
  logic               done;
  logic               done_irq;
  logic               busy;

  dma_mem_if  fetch_mem ();
  dma_mem_if  copy_mem ();
  dma_mem_if  mem_bus ();
  dma_xfer_if xfer ();

  dma_reg_block #(
    .QueueDepth ( QueueDepth )
  ) i_reg_block (
    .clk_i,
    .rst_n_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rvalid_o,
    .reg_rdata_o,
    .desc_valid_o ( desc_valid ),
    .desc_addr_o  ( desc_addr  ),
    .desc_ready_i ( desc_ready ),
    .done_i       ( done       ),
    .done_irq_i   ( done_irq   ),
    .busy_i       ( busy       ),
    .irq_o
  );

  dma_desc_fetch #(
    .PendingDepth ( PendingDepth )
  ) i_desc_fetch (
    .clk_i,
    .rst_n_i,
    .desc_valid_i ( desc_valid ),
    .desc_addr_i  ( desc_addr  ),
    .desc_ready_o ( desc_ready ),
    .done_o       ( done       ),
    .done_irq_o   ( done_irq   ),
    .busy_o       ( busy       ),
    .mem          ( fetch_mem  ),
    .xfer         ( xfer       )
  );

  dma_copy_engine i_copy_engine (
    .clk_i,
    .rst_n_i,
    .xfer ( xfer     ),
    .mem  ( copy_mem )
  );

  dma_mem_arbiter i_mem_arbiter (
    .clk_i,
    .rst_n_i,
    .fetch_mem ( fetch_mem ),
    .copy_mem  ( copy_mem  ),
    .mem       ( mem_bus   )
  );

  assign mem_req_o      = mem_bus.req;
  assign mem_we_o       = mem_bus.we;
  assign mem_addr_o     = mem_bus.addr;
  assign mem_wdata_o    = mem_bus.wdata;
  assign mem_bus.gnt    = mem_gnt_i;
  assign mem_bus.rvalid = mem_rvalid_i;
  assign mem_bus.rdata  = mem_rdata_i;

endmodule

// ==== hw/dma_mem_arbiter.sv ====
// Round-robin arbiter putting the fetcher and the copy engine on one memory port
// The winner owns the port from grant until its rvalid comes back
`timescale 1ns/1ps

module dma_mem_arbiter (
  input  logic      clk_i,
  input  logic      rst_n_i,
  dma_mem_if.slave  fetch_mem,
  dma_mem_if.slave  copy_mem,
  dma_mem_if.master mem
);
  logic busy_q;  // Access outstanding
  logic last_q;  // Last winner and current owner (1 is the copy engine)
  logic sel;

  // On contention the master that did not win last goes first
  assign sel = (fetch_mem.req && copy_mem.req) ? !last_q : copy_mem.req;

  assign mem.req   = !busy_q && (sel ? copy_mem.req : fetch_mem.req);
  assign mem.we    = sel ? copy_mem.we    : fetch_mem.we;
  assign mem.addr  = sel ? copy_mem.addr  : fetch_mem.addr;
  assign mem.wdata = sel ? copy_mem.wdata : fetch_mem.wdata;

  assign fetch_mem.gnt = mem.req && mem.gnt && !sel;
  assign copy_mem.gnt  = mem.req && mem.gnt && sel;

  assign fetch_mem.rvalid = busy_q && mem.rvalid && !last_q;
  assign copy_mem.rvalid  = busy_q && mem.rvalid && last_q;
  assign fetch_mem.rdata  = last_q ? '0 : mem.rdata;
  assign copy_mem.rdata   = last_q ? mem.rdata : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      last_q <= 1'b0;
    end else if (mem.req && mem.gnt) begin
      busy_q <= 1'b1;
      last_q <= sel;
    end else if (mem.rvalid) begin
      busy_q <= 1'b0;
    end
  end

  // A response only arrives for an open access and so always has an owner
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem.rvalid |-> busy_q);

endmodule

// ==== hw/dma_mem_if.sv ====
// Simple request/grant/response memory port
// Every granted access returns exactly one rvalid pulse
`timescale 1ns/1ps

interface dma_mem_if;
  logic               req;
  logic               we;
  dma_cfg_pkg::word_t addr;
  dma_cfg_pkg::word_t wdata;
  logic               gnt;
  logic               rvalid;
  dma_cfg_pkg::word_t rdata;

  modport master (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

// ==== hw/dma_reg_block.sv ====
// Register slave of the DMA holding the descriptor-address queue, the done counter
// and the irq state. Writes take effect at once and reads answer one cycle later
`timescale 1ns/1ps

module dma_reg_block #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               reg_valid_i,
  input  logic               reg_write_i,
  input  dma_cfg_pkg::word_t reg_addr_i,
  input  dma_cfg_pkg::word_t reg_wdata_i,
  output logic               reg_rvalid_o,
  output dma_cfg_pkg::word_t reg_rdata_o,
  output logic               desc_valid_o,
  output dma_cfg_pkg::word_t desc_addr_o,
  input  logic               desc_ready_i,
  input  logic               done_i,
  input  logic               done_irq_i,
  input  logic               busy_i,
  output logic               irq_o
);
  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  dma_cfg_pkg::word_t     fifo_q [QueueDepth];
  logic [PtrW-1:0]        wr_ptr_q;
  logic [PtrW-1:0]        rd_ptr_q;
  logic [CntW-1:0]        count_q;
  dma_cfg_pkg::word_t     done_cnt_q;
  logic                   overflow_q;
  logic                   irq_q;
  dma_cfg_pkg::reg_addr_e reg_addr;
  dma_cfg_pkg::word_t     status;
  logic                   reg_wr;
  logic                   q_write;
  logic                   irq_clear;
  logic                   full;
  logic                   push;
  logic                   pop;

  assign reg_addr  = dma_cfg_pkg::reg_addr_e'(reg_addr_i[dma_cfg_pkg::RegAddrBits-1:0]);
  assign reg_wr    = reg_valid_i && reg_write_i;
  assign q_write   = reg_wr && (reg_addr == dma_cfg_pkg::REG_QUEUE);
  assign irq_clear = reg_wr && (reg_addr == dma_cfg_pkg::REG_IRQ_CLEAR) && reg_wdata_i[0];

  assign full         = (count_q == CntW'(QueueDepth));
  assign push         = q_write && !full;  // Writes to a full queue are dropped
  assign pop          = desc_valid_o && desc_ready_i;
  assign desc_valid_o = (count_q != '0);
  assign desc_addr_o  = fifo_q[rd_ptr_q];
  assign irq_o        = irq_q;

  always_comb begin
    status = '0;
    status[dma_cfg_pkg::StatBusy]     = busy_i || desc_valid_o;
    status[dma_cfg_pkg::StatFull]     = full;
    status[dma_cfg_pkg::StatOverflow] = overflow_q;
    status[dma_cfg_pkg::StatIrq]      = irq_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      done_cnt_q   <= '0;
      overflow_q   <= 1'b0;
      irq_q        <= 1'b0;
      reg_rvalid_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(push) - CntW'(pop);
      if (done_i) begin
        done_cnt_q <= done_cnt_q + 1'b1;
      end
      if (q_write && full) begin
        overflow_q <= 1'b1;
      end else if (irq_clear) begin
        overflow_q <= 1'b0;
      end
      // A new completion wins over a clear in the same cycle
      if (done_i && done_irq_i) begin
        irq_q <= 1'b1;
      end else if (irq_clear) begin
        irq_q <= 1'b0;
      end
      reg_rvalid_o <= reg_valid_i && !reg_write_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= reg_wdata_i;
    end
    if (reg_valid_i && !reg_write_i) begin
      case (reg_addr)
        dma_cfg_pkg::REG_STATUS:     reg_rdata_o <= status;
        dma_cfg_pkg::REG_DONE_COUNT: reg_rdata_o <= done_cnt_q;
        default:                     reg_rdata_o <= '0;
      endcase
    end
  end

  // The level never passes the depth and a full queue has its write pointer
  // on the oldest entry, so no push ever lands on a full queue
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_q <= CntW'(QueueDepth)) && (!full || (wr_ptr_q == rd_ptr_q)));

endmodule

// ==== hw/dma_xfer_if.sv ====
// Copy jobs from the descriptor fetcher to the copy engine and the
// in-order responses back, both as valid/ready channels
`timescale 1ns/1ps

interface dma_xfer_if;
  logic                 job_valid;
  logic                 job_ready;
  dma_cfg_pkg::word_t   job_src;
  dma_cfg_pkg::word_t   job_dst;
  dma_xfer_pkg::len_t   job_len;
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic                 rsp_rejected;

  modport front (
    output job_valid, job_src, job_dst, job_len, rsp_ready,
    input  job_ready, rsp_valid, rsp_rejected
  );

  modport back (
    input  job_valid, job_src, job_dst, job_len, rsp_ready,
    output job_ready, rsp_valid, rsp_rejected
  );

endinterface

// ==== hw/dma_xfer_pkg.sv ====
// Descriptor layout, completion codes and the state encodings of the
// fetcher and the copy engine

package dma_xfer_pkg;

  // Word offsets inside a 4-word descriptor
  typedef enum logic [1:0] {
    DESC_SRC    = 2'd0,
    DESC_DST    = 2'd1,
    DESC_CTRL   = 2'd2,
    DESC_STATUS = 2'd3
  } desc_word_e;

  // DESC_CTRL fields
  localparam int unsigned LenWidth   = 16;
  localparam int unsigned CtrlIrqBit = 31;

  typedef logic [LenWidth-1:0] len_t;

  typedef enum logic [31:0] {
    DESC_DONE     = 32'd1,
    DESC_REJECTED = 32'd2   // Zero length
  } desc_status_e;

  typedef enum logic [2:0] {
    FETCH_IDLE,
    FETCH_RD,
    FETCH_RD_WAIT,
    FETCH_JOB,
    FETCH_WB,
    FETCH_WB_WAIT
  } fetch_state_e;

  typedef enum logic [2:0] {
    COPY_IDLE,
    COPY_RD,
    COPY_RD_WAIT,
    COPY_WR,
    COPY_WR_WAIT,
    COPY_RSP
  } copy_state_e;

endpackage

// ==== src.f ====
hw/dma_cfg_pkg.sv
hw/dma_xfer_pkg.sv
hw/dma_mem_if.sv
hw/dma_xfer_if.sv
hw/dma_reg_block.sv
hw/dma_desc_fetch.sv
hw/dma_copy_engine.sv
hw/dma_mem_arbiter.sv
hw/dma_desc_top.sv
dv/tb_clk_gen.sv
dv/tb_mem_model.sv
dv/tb_dma_desc_top.sv
